//--- design/RvTypes.sv
`default_nettype none

package RvTypes;

    // architectural widths
    localparam int XLen = 32;
    localparam int XLenLog2 = 5;

    // pc step for the link value
    localparam int InsnSize = 4;

    typedef logic [XLen-1:0] word_t;
    typedef logic [4:0] regAddr_t;

endpackage

`default_nettype wire

//--- design/ExecOpTypes.sv
`default_nettype none

package ExecOpTypes;

    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And,
        AluCommand_Clear1,
        AluCommand_Clear2
    } AluCommand;

    typedef enum logic [1:0] {
        AluSrcType1_Zero,
        AluSrcType1_Pc,
        AluSrcType1_Reg
    } AluSrcType1;

    typedef enum logic [1:0] {
        AluSrcType2_Zero,
        AluSrcType2_Imm,
        AluSrcType2_Reg
    } AluSrcType2;

    typedef enum logic [2:0] {
        BranchType_Equal,
        BranchType_NotEqual,
        BranchType_LessThan,
        BranchType_GreaterEqual,
        BranchType_UnsignedLessThan,
        BranchType_UnsignedGreaterEqual,
        BranchType_Always
    } BranchType;

    typedef enum logic [2:0] {
        MulDivType_Mul,
        MulDivType_Mulh,
        MulDivType_Mulhsu,
        MulDivType_Mulhu,
        MulDivType_Div,
        MulDivType_Divu,
        MulDivType_Rem,
        MulDivType_Remu
    } MulDivType;

    typedef enum logic {
        IntResultType_Alu,
        IntResultType_MulDiv
    } IntResultType;

    // cycles from start strobe to done
    localparam int MulLatency = 3;
    localparam int DivLatency = 34;

endpackage

`default_nettype wire

//--- design/OperandCapture.sv
`timescale 1ns/1ps
`default_nettype none

module OperandCapture
    import RvTypes::*;
    import ExecOpTypes::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         busy,
    input  logic         inValid,
    input  word_t        inPc,
    input  word_t        inImm,
    input  word_t        inRs1Value,
    input  word_t        inRs2Value,
    input  regAddr_t     inRd,
    input  AluCommand    inAluCommand,
    input  AluSrcType1   inAluSrc1,
    input  AluSrcType2   inAluSrc2,
    input  logic         inIsBranch,
    input  BranchType    inBranchType,
    input  IntResultType inResultType,
    input  MulDivType    inMulDivType,
    input  logic         inLinkWrite,
    output logic         exValid,
    output word_t        exPc,
    output regAddr_t     exRd,
    output word_t        exRs1Value,
    output word_t        exRs2Value,
    output word_t        exAluSrc1Value,
    output word_t        exAluSrc2Value,
    output AluCommand    exAluCommand,
    output logic         exIsBranch,
    output BranchType    exBranchType,
    output IntResultType exResultType,
    output MulDivType    exMulDivType,
    output logic         exLinkWrite,
    output word_t        exNextPc
);
    logic accept;
    word_t imm;
    AluSrcType1 aluSrc1;
    AluSrcType2 aluSrc2;

    // issue while busy is dropped
    assign accept = inValid && !busy && !flush;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            exValid <= 1'b0;
        end else begin
            exValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            exPc <= inPc;
            imm <= inImm;
            exRs1Value <= inRs1Value;
            exRs2Value <= inRs2Value;
            exRd <= inRd;
            exAluCommand <= inAluCommand;
            aluSrc1 <= inAluSrc1;
            aluSrc2 <= inAluSrc2;
            exIsBranch <= inIsBranch;
            exBranchType <= inBranchType;
            exResultType <= inResultType;
            exMulDivType <= inMulDivType;
            exLinkWrite <= inLinkWrite;
        end
    end

    always_comb begin
        unique case (aluSrc1)
            AluSrcType1_Zero: exAluSrc1Value = '0;
            AluSrcType1_Pc:   exAluSrc1Value = exPc;
            AluSrcType1_Reg:  exAluSrc1Value = exRs1Value;
            default:          exAluSrc1Value = '0;
        endcase

        unique case (aluSrc2)
            AluSrcType2_Zero: exAluSrc2Value = '0;
            AluSrcType2_Imm:  exAluSrc2Value = imm;
            AluSrcType2_Reg:  exAluSrc2Value = exRs2Value;
            default:          exAluSrc2Value = '0;
        endcase

        // link value for jal/jalr
        exNextPc = exPc + word_t'(InsnSize);
    end

endmodule

`default_nettype wire

//--- design/IntAlu.sv
`timescale 1ns/1ps
`default_nettype none

module IntAlu
    import RvTypes::*;
    import ExecOpTypes::*;
(
    input  AluCommand aluCommand,
    input  word_t     src1,
    input  word_t     src2,
    input  BranchType branchType,
    input  logic      isBranch,
    input  word_t     rs1,
    input  word_t     rs2,
    output word_t     aluResult,
    output logic      branchTaken
);
    logic [XLenLog2-1:0] shamt;
    logic compare;

    assign shamt = src2[XLenLog2-1:0];

    always_comb begin
        unique case (aluCommand)
            AluCommand_Add:    aluResult = src1 + src2;
            AluCommand_Sub:    aluResult = src1 - src2;
            AluCommand_Sll:    aluResult = src1 << shamt;
            AluCommand_Slt:    aluResult = word_t'($signed(src1) < $signed(src2));
            AluCommand_Sltu:   aluResult = word_t'(src1 < src2);
            AluCommand_Xor:    aluResult = src1 ^ src2;
            AluCommand_Srl:    aluResult = src1 >> shamt;
            AluCommand_Sra:    aluResult = word_t'($signed(src1) >>> shamt);
            AluCommand_Or:     aluResult = src1 | src2;
            AluCommand_And:    aluResult = src1 & src2;
            AluCommand_Clear1: aluResult = src1 & ~src2;
            AluCommand_Clear2: aluResult = ~src1 & src2;
            default:           aluResult = '0;
        endcase
    end

    // comparator works on the raw register values
    always_comb begin
        unique case (branchType)
            BranchType_Equal:                compare = rs1 == rs2;
            BranchType_NotEqual:             compare = rs1 != rs2;
            BranchType_LessThan:             compare = $signed(rs1) < $signed(rs2);
            BranchType_GreaterEqual:         compare = $signed(rs1) >= $signed(rs2);
            BranchType_UnsignedLessThan:     compare = rs1 < rs2;
            BranchType_UnsignedGreaterEqual: compare = rs1 >= rs2;
            BranchType_Always:               compare = 1'b1;
            default:                         compare = 1'b0;
        endcase
    end

    assign branchTaken = isBranch && compare;

endmodule

`default_nettype wire

//--- design/MulUnit.sv
`timescale 1ns/1ps
`default_nettype none

module MulUnit
    import RvTypes::*;
    import ExecOpTypes::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      start,
    input  MulDivType mulDivType,
    input  word_t     src1,
    input  word_t     src2,
    output logic      done,
    output word_t     result
);
    logic signed1;
    logic signed2;
    logic highHalf;
    logic signed [XLen:0] op1;
    logic signed [XLen:0] op2;
    logic high1;
    logic high2;
    logic [2*XLen-1:0] product;
    logic [MulLatency-1:0] validPipe;

    always_comb begin
        signed1 = (mulDivType == MulDivType_Mulh) || (mulDivType == MulDivType_Mulhsu);
        signed2 = mulDivType == MulDivType_Mulh;
        highHalf = mulDivType != MulDivType_Mul;
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            validPipe <= '0;
        end else begin
            validPipe <= {validPipe[MulLatency-2:0], start};
        end
    end

    // operands, product, half select
    always_ff @(posedge clk) begin
        op1 <= {signed1 & src1[XLen-1], src1};
        op2 <= {signed2 & src2[XLen-1], src2};
        high1 <= highHalf;
        product <= op1 * op2;
        high2 <= high1;
        result <= high2 ? product[2*XLen-1:XLen] : product[XLen-1:0];
    end

    assign done = validPipe[MulLatency-1];

endmodule

`default_nettype wire

//--- design/DivUnit.sv
`timescale 1ns/1ps
`default_nettype none

module DivUnit
    import RvTypes::*;
    import ExecOpTypes::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  logic      start,
    input  MulDivType mulDivType,
    input  word_t     dividend,
    input  word_t     divisor,
    output logic      done,
    output word_t     quotient,
    output word_t     remainder
);
    logic active;
    logic [XLenLog2:0] count;
    word_t remReg;
    word_t quoReg;
    word_t divisorMag;
    logic negQuotient;
    logic negRemainder;
    logic divByZero;
    logic isSigned;
    logic dividendNeg;
    logic divisorNeg;
    logic [XLen:0] shifted;
    logic [XLen+1:0] trial;

    always_comb begin
        isSigned = (mulDivType == MulDivType_Div) || (mulDivType == MulDivType_Rem);
        dividendNeg = isSigned && dividend[XLen-1];
        divisorNeg = isSigned && divisor[XLen-1];
        shifted = {remReg, quoReg[XLen-1]};
        trial = {1'b0, shifted} - {2'b00, divisorMag};
    end

    // one load cycle, 32 steps, one fixup cycle
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            active <= 1'b0;
            done <= 1'b0;
            count <= '0;
        end else begin
            done <= 1'b0;
            if (start) begin
                active <= 1'b1;
                count <= '0;
            end else if (active) begin
                if (count[XLenLog2]) begin
                    active <= 1'b0;
                    done <= 1'b1;
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            remReg <= '0;
            quoReg <= dividendNeg ? -dividend : dividend;
            divisorMag <= divisorNeg ? -divisor : divisor;
            negQuotient <= dividendNeg ^ divisorNeg;
            negRemainder <= dividendNeg;
            divByZero <= divisor == '0;
        end else if (active && !count[XLenLog2]) begin
            if (!trial[XLen+1]) begin
                remReg <= trial[XLen-1:0];
                quoReg <= {quoReg[XLen-2:0], 1'b1};
            end else begin
                remReg <= shifted[XLen-1:0];
                quoReg <= {quoReg[XLen-2:0], 1'b0};
            end
        end else if (active) begin
            // overflow already yields dividend and zero here
            quotient <= divByZero ? '1 : (negQuotient ? -quoReg : quoReg);
            remainder <= negRemainder ? -remReg : remReg;
        end
    end

endmodule

`default_nettype wire

//--- design/ExecWriteback.sv
`timescale 1ns/1ps
`default_nettype none

module ExecWriteback
    import RvTypes::*;
    import ExecOpTypes::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         exValid,
    input  regAddr_t     exRd,
    input  IntResultType exResultType,
    input  MulDivType    exMulDivType,
    input  logic         exLinkWrite,
    input  word_t        exNextPc,
    input  word_t        aluResult,
    input  logic         branchTaken,
    input  logic         mulDone,
    input  word_t        mulResult,
    input  logic         divDone,
    input  word_t        divQuotient,
    input  word_t        divRemainder,
    output logic         mulStart,
    output logic         divStart,
    output logic         busy,
    output logic         outValid,
    output regAddr_t     outRd,
    output word_t        outValue,
    output logic         outBranchTaken,
    output word_t        outBranchTarget
);
    logic exMulDiv;
    logic exIsMul;
    logic aluRetire;
    logic mulDivRetire;
    logic pending;
    logic pendingIsMul;
    logic pendingRem;
    regAddr_t pendingRd;
    word_t mulDivValue;

    always_comb begin
        exMulDiv = exValid && (exResultType == IntResultType_MulDiv);
        exIsMul = exMulDivType inside {MulDivType_Mul, MulDivType_Mulh,
                                       MulDivType_Mulhsu, MulDivType_Mulhu};
        mulStart = exMulDiv && exIsMul && !flush;
        divStart = exMulDiv && !exIsMul && !flush;
        // high from capture until the result leaves
        busy = pending || exMulDiv;
        aluRetire = exValid && (exResultType == IntResultType_Alu);
        mulDivRetire = pending && (pendingIsMul ? mulDone : divDone);
        if (pendingIsMul) begin
            mulDivValue = mulResult;
        end else begin
            mulDivValue = pendingRem ? divRemainder : divQuotient;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            pending <= 1'b0;
            outValid <= 1'b0;
        end else begin
            outValid <= aluRetire || mulDivRetire;
            if (mulStart || divStart) begin
                pending <= 1'b1;
            end else if (mulDivRetire) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (exMulDiv) begin
            pendingRd <= exRd;
            pendingIsMul <= exIsMul;
            pendingRem <= exMulDivType inside {MulDivType_Rem, MulDivType_Remu};
        end
        if (aluRetire) begin
            outRd <= exRd;
            outValue <= exLinkWrite ? exNextPc : aluResult;
            outBranchTaken <= branchTaken;
            outBranchTarget <= aluResult;
        end else if (mulDivRetire) begin
            outRd <= pendingRd;
            outValue <= mulDivValue;
            outBranchTaken <= 1'b0;
            outBranchTarget <= '0;
        end
    end

endmodule

`default_nettype wire

//--- design/ExecuteStage.sv
`timescale 1ns/1ps
`default_nettype none

module ExecuteStage
    import RvTypes::*;
    import ExecOpTypes::*;
(
    input  logic         clk,
    input  logic         rst,
    input  logic         flush,
    input  logic         inValid,
    input  word_t        inPc,
    input  word_t        inImm,
    input  word_t        inRs1Value,
    input  word_t        inRs2Value,
    input  regAddr_t     inRd,
    input  AluCommand    inAluCommand,
    input  AluSrcType1   inAluSrc1,
    input  AluSrcType2   inAluSrc2,
    input  logic         inIsBranch,
    input  BranchType    inBranchType,
    input  IntResultType inResultType,
    input  MulDivType    inMulDivType,
    input  logic         inLinkWrite,
    output logic         busy,
    output logic         outValid,
    output regAddr_t     outRd,
    output word_t        outValue,
    output logic         outBranchTaken,
    output word_t        outBranchTarget
);
    logic exValid;
    regAddr_t exRd;
    word_t exRs1Value;
    word_t exRs2Value;
    word_t exAluSrc1Value;
    word_t exAluSrc2Value;
    AluCommand exAluCommand;
    logic exIsBranch;
    BranchType exBranchType;
    IntResultType exResultType;
    MulDivType exMulDivType;
    logic exLinkWrite;
    word_t exNextPc;
    word_t aluResult;
    logic branchTaken;
    logic mulStart;
    logic mulDone;
    word_t mulResult;
    logic divStart;
    logic divDone;
    word_t divQuotient;
    word_t divRemainder;

    OperandCapture capture (
        .clk, .rst, .flush, .busy,
        .inValid, .inPc, .inImm, .inRs1Value, .inRs2Value, .inRd,
        .inAluCommand, .inAluSrc1, .inAluSrc2, .inIsBranch, .inBranchType,
        .inResultType, .inMulDivType, .inLinkWrite,
        .exValid, .exPc(), .exRd, .exRs1Value, .exRs2Value,
        .exAluSrc1Value, .exAluSrc2Value, .exAluCommand, .exIsBranch,
        .exBranchType, .exResultType, .exMulDivType, .exLinkWrite, .exNextPc
    );

    IntAlu alu (
        .aluCommand(exAluCommand),
        .src1(exAluSrc1Value),
        .src2(exAluSrc2Value),
        .branchType(exBranchType),
        .isBranch(exIsBranch),
        .rs1(exRs1Value),
        .rs2(exRs2Value),
        .aluResult,
        .branchTaken
    );

    MulUnit mul (
        .clk, .rst, .flush,
        .start(mulStart),
        .mulDivType(exMulDivType),
        .src1(exRs1Value),
        .src2(exRs2Value),
        .done(mulDone),
        .result(mulResult)
    );

    DivUnit div (
        .clk, .rst, .flush,
        .start(divStart),
        .mulDivType(exMulDivType),
        .dividend(exRs1Value),
        .divisor(exRs2Value),
        .done(divDone),
        .quotient(divQuotient),
        .remainder(divRemainder)
    );

    ExecWriteback writeback (
        .clk, .rst, .flush,
        .exValid, .exRd, .exResultType, .exMulDivType, .exLinkWrite, .exNextPc,
        .aluResult, .branchTaken,
        .mulDone, .mulResult, .divDone, .divQuotient, .divRemainder,
        .mulStart, .divStart, .busy,
        .outValid, .outRd, .outValue, .outBranchTaken, .outBranchTarget
    );

endmodule

`default_nettype wire

//--- sim/ExecModel.svh
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

function automatic word_t aluModel(AluCommand cmd, word_t a, word_t b);
    logic [4:0] sh;
    sh = b[4:0];
    case (cmd)
        AluCommand_Add:    return a + b;
        AluCommand_Sub:    return a - b;
        AluCommand_Sll:    return a << sh;
        // flipping the sign bits turns a signed compare into an unsigned one
        AluCommand_Slt:    return ({~a[31], a[30:0]} < {~b[31], b[30:0]}) ? 32'd1 : 32'd0;
        AluCommand_Sltu:   return (a < b) ? 32'd1 : 32'd0;
        AluCommand_Xor:    return a ^ b;
        AluCommand_Srl:    return a >> sh;
        AluCommand_Sra:    return a[31] ? ((a >> sh) | ~(32'hFFFF_FFFF >> sh)) : (a >> sh);
        AluCommand_Or:     return a | b;
        AluCommand_And:    return a & b;
        AluCommand_Clear1: return a & ~b;
        AluCommand_Clear2: return ~a & b;
        default:           return 32'd0;
    endcase
endfunction

function automatic logic branchModel(BranchType kind, word_t a, word_t b);
    case (kind)
        BranchType_Equal:                return a == b;
        BranchType_NotEqual:             return a != b;
        BranchType_LessThan:             return {~a[31], a[30:0]} < {~b[31], b[30:0]};
        BranchType_GreaterEqual:         return !({~a[31], a[30:0]} < {~b[31], b[30:0]});
        BranchType_UnsignedLessThan:     return a < b;
        BranchType_UnsignedGreaterEqual: return !(a < b);
        BranchType_Always:               return 1'b1;
        default:                         return 1'b0;
    endcase
endfunction

function automatic word_t mulModel(MulDivType kind, word_t a, word_t b);
    logic [63:0] wideA;
    logic [63:0] wideB;
    logic [63:0] product;
    // mulh extends both signs, mulhsu only the first
    if (kind == MulDivType_Mulh || kind == MulDivType_Mulhsu) begin
        wideA = {{32{a[31]}}, a};
    end else begin
        wideA = {32'd0, a};
    end
    wideB = (kind == MulDivType_Mulh) ? {{32{b[31]}}, b} : {32'd0, b};
    product = wideA * wideB;
    return (kind == MulDivType_Mul) ? product[31:0] : product[63:32];
endfunction

function automatic word_t divModel(MulDivType kind, word_t a, word_t b);
    logic signedOp;
    logic wantRem;
    word_t q;
    word_t r;
    signedOp = (kind == MulDivType_Div) || (kind == MulDivType_Rem);
    wantRem = (kind == MulDivType_Rem) || (kind == MulDivType_Remu);
    if (b == 32'd0) begin
        q = 32'hFFFF_FFFF;
        r = a;
    end else if (signedOp && a == 32'h8000_0000 && b == 32'hFFFF_FFFF) begin
        q = a;
        r = 32'd0;
    end else if (signedOp) begin
        q = word_t'($signed(a) / $signed(b));
        r = word_t'($signed(a) % $signed(b));
    end else begin
        q = a / b;
        r = a % b;
    end
    return wantRem ? r : q;
endfunction

function automatic logic isMulKind(MulDivType kind);
    return kind inside {MulDivType_Mul, MulDivType_Mulh, MulDivType_Mulhsu, MulDivType_Mulhu};
endfunction

function automatic int latencyModel(IntResultType resultKind, MulDivType kind);
    if (resultKind == IntResultType_Alu) begin
        return 2;
    end
    return isMulKind(kind) ? 2 + MulLatency : 2 + DivLatency;
endfunction

`endif

//--- sim/ExecuteStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module ExecuteStageTb
    import RvTypes::*;
    import ExecOpTypes::*;
();
    localparam int ClkPeriod = 8;
    localparam int NumAluOps = 150;
    localparam int NumBranchOps = 80;
    localparam int NumRandomMul = 24;
    localparam int NumRandomDiv = 16;
    localparam int TotalOps = NumAluOps + NumBranchOps + NumRandomMul + NumRandomDiv + 36;
    localparam int WatchdogCycles = TotalOps * 40;
    localparam int DrainLimit = 2 + DivLatency + 8;

    `include "ExecModel.svh"

    logic clk = 1'b0;
    logic rst;
    logic flush;
    logic inValid;
    word_t inPc;
    word_t inImm;
    word_t inRs1Value;
    word_t inRs2Value;
    regAddr_t inRd;
    AluCommand inAluCommand;
    AluSrcType1 inAluSrc1;
    AluSrcType2 inAluSrc2;
    logic inIsBranch;
    BranchType inBranchType;
    IntResultType inResultType;
    MulDivType inMulDivType;
    logic inLinkWrite;
    logic busy;
    logic outValid;
    regAddr_t outRd;
    word_t outValue;
    logic outBranchTaken;
    word_t outBranchTarget;

    int cycleCount = 0;
    int mismatchCount = 0;
    int otherErrors = 0;

    // scoreboard, one entry per accepted operation
    string expName[$];
    regAddr_t expRd[$];
    word_t expValue[$];
    logic expTaken[$];
    word_t expTarget[$];
    logic expIsAlu[$];
    int expCycle[$];

    ExecuteStage dut (
        .clk, .rst, .flush,
        .inValid, .inPc, .inImm, .inRs1Value, .inRs2Value, .inRd,
        .inAluCommand, .inAluSrc1, .inAluSrc2, .inIsBranch, .inBranchType,
        .inResultType, .inMulDivType, .inLinkWrite,
        .busy, .outValid, .outRd, .outValue, .outBranchTaken, .outBranchTarget
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    task automatic compareValue(input string testName, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %h actual %h", testName, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic clearExpected();
        expName.delete();
        expRd.delete();
        expValue.delete();
        expTaken.delete();
        expTarget.delete();
        expIsAlu.delete();
        expCycle.delete();
    endtask

    function automatic word_t randomOperand();
        word_t value;
        value = $urandom;
        // corner values now and then
        if ($urandom % 4 == 0) begin
            case ($urandom % 5)
                0: value = 32'h0000_0000;
                1: value = 32'hFFFF_FFFF;
                2: value = 32'h8000_0000;
                3: value = 32'h7FFF_FFFF;
                default: value = 32'h0000_0001;
            endcase
        end
        return value;
    endfunction

    function automatic logic [63:0] edgePair(logic forDiv, int idx);
        if (!forDiv) begin
            case (idx)
                0: return {32'h0000_0000, 32'hFFFF_FFFF};
                1: return {32'hFFFF_FFFF, 32'hFFFF_FFFF};
                2: return {32'h8000_0000, 32'h8000_0000};
                default: return {32'h8000_0000, 32'hFFFF_FFFF};
            endcase
        end
        case (idx)
            0: return {32'h1234_5678, 32'h0000_0000};
            1: return {32'h8000_0000, 32'hFFFF_FFFF};
            2: return {32'hFFFF_FFF9, 32'h0000_0002};
            default: return {32'h0000_0007, 32'hFFFF_FFFE};
        endcase
    endfunction

    // drives one strobe a little after the edge
    task automatic driveOp(input string testName, input logic push,
                           input word_t pc, input word_t imm,
                           input word_t rs1, input word_t rs2, input regAddr_t rd,
                           input AluCommand cmd, input AluSrcType1 src1Kind,
                           input AluSrcType2 src2Kind, input logic isBranch,
                           input BranchType branchKind, input IntResultType resultKind,
                           input MulDivType mulDivKind, input logic linkWrite);
        word_t a;
        word_t b;
        word_t aluValue;
        @(posedge clk);
        #1;
        inValid = 1'b1;
        inPc = pc;
        inImm = imm;
        inRs1Value = rs1;
        inRs2Value = rs2;
        inRd = rd;
        inAluCommand = cmd;
        inAluSrc1 = src1Kind;
        inAluSrc2 = src2Kind;
        inIsBranch = isBranch;
        inBranchType = branchKind;
        inResultType = resultKind;
        inMulDivType = mulDivKind;
        inLinkWrite = linkWrite;
        if (push) begin
            a = (src1Kind == AluSrcType1_Pc) ? pc : (src1Kind == AluSrcType1_Reg) ? rs1 : '0;
            b = (src2Kind == AluSrcType2_Imm) ? imm : (src2Kind == AluSrcType2_Reg) ? rs2 : '0;
            aluValue = aluModel(cmd, a, b);
            expName.push_back(testName);
            expRd.push_back(rd);
            expIsAlu.push_back(resultKind == IntResultType_Alu);
            expCycle.push_back(cycleCount + latencyModel(resultKind, mulDivKind));
            if (resultKind == IntResultType_Alu) begin
                expValue.push_back(linkWrite ? pc + word_t'(InsnSize) : aluValue);
                expTaken.push_back(isBranch && branchModel(branchKind, rs1, rs2));
                expTarget.push_back(aluValue);
            end else begin
                if (isMulKind(mulDivKind)) begin
                    expValue.push_back(mulModel(mulDivKind, rs1, rs2));
                end else begin
                    expValue.push_back(divModel(mulDivKind, rs1, rs2));
                end
                expTaken.push_back(1'b0);
                expTarget.push_back('0);
            end
        end
    endtask

    task automatic endBurst();
        @(posedge clk);
        #1;
        inValid = 1'b0;
    endtask

    task automatic waitDrain(input string testName);
        int waited;
        waited = 0;
        while (expValue.size() != 0 && waited < DrainLimit) begin
            @(posedge clk);
            waited++;
        end
        if (expValue.size() != 0) begin
            $display("%s: %0d results never arrived", testName, expValue.size());
            otherErrors++;
            clearExpected();
        end
    endtask

    task automatic randomAluOp(input string testName, input logic push);
        driveOp(testName, push, $urandom & 32'hFFFF_FFFC, randomOperand(),
                randomOperand(), randomOperand(), 5'($urandom % 32),
                AluCommand'(4'($urandom % 12)), AluSrcType1'(2'($urandom % 3)),
                AluSrcType2'(2'($urandom % 3)), 1'b0, BranchType_Equal,
                IntResultType_Alu, MulDivType_Mul, 1'b0);
    endtask

    task automatic randomBranchOp(input string testName);
        word_t rs1;
        word_t rs2;
        rs1 = randomOperand();
        // equal operands a quarter of the time
        rs2 = ($urandom % 4 == 0) ? rs1 : randomOperand();
        driveOp(testName, 1'b1, $urandom & 32'hFFFF_FFFC, $urandom, rs1, rs2,
                5'($urandom % 32), AluCommand_Add,
                ($urandom % 2 == 0) ? AluSrcType1_Pc : AluSrcType1_Reg,
                AluSrcType2_Imm, 1'b1, BranchType'(3'($urandom % 7)),
                IntResultType_Alu, MulDivType_Mul, 1'($urandom % 2));
    endtask

    task automatic runMulDiv(input string testName, input MulDivType kind,
                             input word_t a, input word_t b, input logic probe);
        int issueCycle;
        int lat;
        driveOp(testName, 1'b1, $urandom & 32'hFFFF_FFFC, $urandom, a, b,
                5'($urandom % 32), AluCommand_Add, AluSrcType1_Reg, AluSrcType2_Reg,
                1'b0, BranchType_Equal, IntResultType_MulDiv, kind, 1'b0);
        issueCycle = cycleCount;
        lat = latencyModel(IntResultType_MulDiv, kind);
        // a strobe while busy must vanish
        if (probe) begin
            randomAluOp({testName, " dropped"}, 1'b0);
        end
        endBurst();
        while (cycleCount < issueCycle + lat) begin
            @(negedge clk);
            if (cycleCount > issueCycle && cycleCount < issueCycle + lat) begin
                compareValue({testName, " busy"}, 32'd1, 32'(busy));
            end
        end
        compareValue({testName, " busy clear"}, 32'd0, 32'(busy));
        waitDrain(testName);
    endtask

    task automatic flushDuring(input string testName, input MulDivType kind, input int delay);
        // flushed op gets no scoreboard entry
        driveOp(testName, 1'b0, 32'h0000_1000, 32'd0, randomOperand(), randomOperand(),
                5'd9, AluCommand_Add, AluSrcType1_Reg, AluSrcType2_Reg, 1'b0,
                BranchType_Equal, IntResultType_MulDiv, kind, 1'b0);
        endBurst();
        repeat (delay) @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        @(negedge clk);
        compareValue({testName, " busy after flush"}, 32'd0, 32'(busy));
        repeat (2 + DivLatency + 4) @(posedge clk);
        randomAluOp(testName, 1'b1);
        endBurst();
        waitDrain(testName);
    endtask

    always @(negedge clk) begin : monitor
        string name;
        logic isAlu;
        logic taken;
        word_t target;
        if (!rst && outValid) begin
            if (expValue.size() == 0) begin
                $display("cycle %0d: outValid with no operation in flight", cycleCount);
                otherErrors++;
            end else begin
                name = expName.pop_front();
                isAlu = expIsAlu.pop_front();
                taken = expTaken.pop_front();
                target = expTarget.pop_front();
                compareValue({name, " cycle"}, 32'(expCycle.pop_front()), 32'(cycleCount));
                compareValue({name, " rd"}, 32'(expRd.pop_front()), 32'(outRd));
                compareValue({name, " value"}, expValue.pop_front(), outValue);
                if (isAlu) begin
                    compareValue({name, " taken"}, 32'(taken), 32'(outBranchTaken));
                    compareValue({name, " target"}, target, outBranchTarget);
                end
            end
        end
    end

    initial begin : watchdog
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, tests did not finish", WatchdogCycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [63:0] pair;
        void'($urandom(58));
        rst = 1'b1;
        flush = 1'b0;
        inValid = 1'b0;
        inPc = '0;
        inImm = '0;
        inRs1Value = '0;
        inRs2Value = '0;
        inRd = '0;
        inAluCommand = AluCommand_Add;
        inAluSrc1 = AluSrcType1_Zero;
        inAluSrc2 = AluSrcType2_Zero;
        inIsBranch = 1'b0;
        inBranchType = BranchType_Equal;
        inResultType = IntResultType_Alu;
        inMulDivType = MulDivType_Mul;
        inLinkWrite = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int i = 0; i < NumAluOps; i++) begin
            randomAluOp("alu", 1'b1);
        end
        endBurst();
        waitDrain("alu");

        for (int i = 0; i < NumBranchOps; i++) begin
            randomBranchOp("branch");
        end
        endBurst();
        waitDrain("branch");

        // edge operands first, then random ones
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                pair = edgePair(1'b0, j);
                runMulDiv("mul", MulDivType'(3'(i)), pair[63:32], pair[31:0], j[0]);
            end
        end
        for (int i = 0; i < NumRandomMul; i++) begin
            runMulDiv("mul", MulDivType'(3'($urandom % 4)), randomOperand(),
                      randomOperand(), 1'b0);
        end

        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                pair = edgePair(1'b1, j);
                runMulDiv("div", MulDivType'(3'(4 + i)), pair[63:32], pair[31:0], 1'b1);
            end
        end
        for (int i = 0; i < NumRandomDiv; i++) begin
            runMulDiv("div", MulDivType'(3'(4 + $urandom % 4)), randomOperand(),
                      randomOperand(), i[0]);
        end

        flushDuring("flush div", MulDivType_Div, 10);
        flushDuring("flush mul", MulDivType_Mulh, 1);

        $display("errors: %0d mismatches, %0d other failures", mismatchCount, otherErrors);
        if (mismatchCount == 0 && otherErrors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- execStage.f
+incdir+sim
design/RvTypes.sv
design/ExecOpTypes.sv
design/OperandCapture.sv
design/IntAlu.sv
design/MulUnit.sv
design/DivUnit.sv
design/ExecWriteback.sv
design/ExecuteStage.sv
sim/ExecuteStageTb.sv

//--- Makefile
TOP := ExecuteStageTb

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f execStage.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
